//--- logic/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define BOOT_ADDR   32'hffc0_0000

// addressing modes, IR bits 31:29
`define MODE_REG    3'h3
`define MODE_INH    3'h4
`define MODE_IMM2   3'h5
`define MODE_DIR    3'h6
`define MODE_IMM3A  3'h7

`define ALU_AND     4'd0
`define ALU_OR      4'd1
`define ALU_ADD     4'd2
`define ALU_SUB     4'd3
`define ALU_XOR     4'd4

// inherent ops, high nibble of op byte
`define OP_NOP      4'h0
`define OP_CMP      4'h4
`define OP_INC      4'h6
`define OP_DEC      4'h8
`define OP_MOV      4'he

`define BR_BRA      5'd0
`define BR_BEQ      5'd1
`define BR_BNE      5'd2
`define BR_BGEU     5'd8
`define BR_BLTU     5'd9

`define OP_STDL     8'h00
`define OP_LDDL     8'h01

`endif

//--- logic/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [15:0] half_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  alu_func_t;

  // {carry, negative, overflow, zero}
  typedef logic [3:0]  flags_t;

  typedef enum logic [2:0] {
    FETCH,
    FETCH_WAIT,
    EVAL1,
    EVAL2,
    EVAL3,
    MEM_WAIT,
    LOAD_WB,
    FAULT
  } ctrl_state_t;

endpackage

//--- logic/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if import cpu_pkg::*; ();

  logic  req;      // one-cycle request strobe
  logic  is_long;  // two halves, high first
  logic  write;
  word_t addr;
  word_t wdata;
  word_t rdata;
  logic  done;

  modport ctrl (
    output req,
    output is_long,
    output write,
    output addr,
    output wdata,
    input  rdata,
    input  done
  );

  modport bus (
    input  req,
    input  is_long,
    input  write,
    input  addr,
    input  wdata,
    output rdata,
    output done
  );

endinterface

//--- logic/bus_unit.sv
`timescale 1ns/1ps

module bus_unit import cpu_pkg::*; (
  input  logic       csi_clk,
  input  logic       rsi_reset_n,
  mem_req_if.bus     req,
  input  logic       avm_m0_waitrequest,
  input  half_t      avm_m0_readdata,
  output word_t      avm_m0_address,
  output logic       avm_m0_read,
  output logic       avm_m0_write,
  output half_t      avm_m0_writedata,
  output logic [1:0] avm_m0_byteenable
);

  typedef enum logic [1:0] {
    BU_IDLE,
    BU_HIGH,
    BU_LOW,
    BU_GAP
  } bu_state_t;

  bu_state_t state;
  logic      half_sel; // 1 selects the low half at addr+2
  logic      accept;

  assign accept = (avm_m0_read | avm_m0_write) & ~avm_m0_waitrequest;

  assign avm_m0_address    = half_sel ? req.addr + 32'd2 : req.addr;
  assign avm_m0_writedata  = (half_sel | ~req.is_long) ? req.wdata[15:0] : req.wdata[31:16];
  assign avm_m0_byteenable = 2'b11; // word access only

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      state        <= BU_IDLE;
      half_sel     <= 1'b0;
      avm_m0_read  <= 1'b0;
      avm_m0_write <= 1'b0;
      req.done     <= 1'b0;
    end else begin
      req.done <= 1'b0;
      case (state)
        BU_IDLE: begin
          if (req.req) begin
            half_sel     <= 1'b0;
            avm_m0_read  <= ~req.write;
            avm_m0_write <= req.write;
            state        <= BU_HIGH;
          end
        end
        BU_HIGH: begin
          if (accept) begin
            avm_m0_read  <= 1'b0;
            avm_m0_write <= 1'b0;
            if (req.is_long) begin
              half_sel <= 1'b1;
              state    <= BU_GAP;
            end else begin
              req.done <= 1'b1;
              state    <= BU_IDLE;
            end
          end
        end
        BU_GAP: begin // strobes low for one cycle between halves
          avm_m0_read  <= ~req.write;
          avm_m0_write <= req.write;
          state        <= BU_LOW;
        end
        BU_LOW: begin
          if (accept) begin
            avm_m0_read  <= 1'b0;
            avm_m0_write <= 1'b0;
            req.done     <= 1'b1;
            state        <= BU_IDLE;
          end
        end
        default: state <= BU_IDLE;
      endcase
    end
  end

  // read data assembly, big-endian
  always_ff @(posedge csi_clk) begin
    if (accept && avm_m0_read) begin
      if (!req.is_long) begin
        req.rdata <= {16'h0000, avm_m0_readdata};
      end else if (!half_sel) begin
        req.rdata[31:16] <= avm_m0_readdata;
      end else begin
        req.rdata[15:0] <= avm_m0_readdata;
      end
    end
  end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module alu import cpu_pkg::*; (
  input  alu_func_t func,
  input  word_t     in1,
  input  word_t     in2,
  output word_t     result,
  output flags_t    flags
);

  logic [32:0] sum;
  logic        carry;
  logic        overflow;

  always_comb begin
    sum      = '0;
    carry    = 1'b0;
    overflow = 1'b0;
    case (func)
      `ALU_AND: result = in1 & in2;
      `ALU_OR:  result = in1 | in2;
      `ALU_XOR: result = in1 ^ in2;
      `ALU_ADD: begin
        sum      = {1'b0, in1} + {1'b0, in2};
        result   = sum[31:0];
        carry    = sum[32];
        overflow = (in1[31] == in2[31]) && (sum[31] != in1[31]);
      end
      `ALU_SUB: begin
        sum      = {1'b0, in1} - {1'b0, in2};
        result   = sum[31:0];
        carry    = sum[32]; // borrow
        overflow = (in1[31] != in2[31]) && (sum[31] != in1[31]);
      end
      default: result = '0;
    endcase
  end

  assign flags = {carry, result[31], overflow, result == 32'd0};

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
  input  logic      csi_clk,
  input  logic      rsi_reset_n,
  input  reg_addr_t rd_addr1,
  input  reg_addr_t rd_addr2,
  output word_t     rd_data1,
  output word_t     rd_data2,
  input  logic      wr_en,
  input  reg_addr_t wr_addr,
  input  word_t     wr_data
);

  word_t regs [32];

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rd_data1 = regs[rd_addr1];
  assign rd_data2 = regs[rd_addr2];

endmodule

//--- logic/cpu_control.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_control import cpu_pkg::*; (
  input  logic      csi_clk,
  input  logic      rsi_reset_n,
  mem_req_if.ctrl   mem,
  output reg_addr_t rd_addr1,
  output reg_addr_t rd_addr2,
  input  word_t     rd_data1,
  input  word_t     rd_data2,
  output logic      wr_en,
  output reg_addr_t wr_addr,
  output word_t     wr_data,
  output alu_func_t alu_func,
  output word_t     alu_in1,
  output word_t     alu_in2,
  input  word_t     alu_result,
  input  flags_t    alu_flags
);

  ctrl_state_t state;
  word_t       pc;
  word_t       ir;
  word_t       mar;
  word_t       mdr;
  flags_t      ccr;
  logic [1:0]  word_idx; // instruction word being fetched
  logic [2:0]  ir_mode;
  logic [7:0]  ir_op;
  reg_addr_t   ir_ra;
  reg_addr_t   ir_rb;
  reg_addr_t   ir_rc;
  logic        alu_op_ok;
  logic        is_ldi;
  logic        is_dir_mem;
  logic        br_valid;
  logic        br_taken;

  assign ir_mode = ir[31:29];
  assign ir_ra   = ir[20:16];
  assign ir_rb   = ir[25:21];
  assign ir_rc   = ir[4:0];
  // inherent ops keep only bits 28:26, rB shares the rest
  assign ir_op   = ir[31] ? ((ir[30:29] == 2'b00) ? {ir[28:26], 5'b00000} : ir[28:21])
                          : {ir[28:26], ir[15:11]};

  assign alu_op_ok  = !ir_op[5] && (ir_op[3:0] <= `ALU_XOR);
  assign is_ldi     = (ir_mode == `MODE_IMM3A) && (ir_op == 8'h00);
  assign is_dir_mem = (ir_mode == `MODE_DIR) && (ir_op == `OP_STDL || ir_op == `OP_LDDL);

  always_comb begin
    br_valid = 1'b1;
    case (ir_op[4:0])
      `BR_BRA:  br_taken = 1'b1;
      `BR_BEQ:  br_taken = ccr[0];
      `BR_BNE:  br_taken = ~ccr[0];
      `BR_BLTU: br_taken = ccr[3];
      `BR_BGEU: br_taken = ~ccr[3];
      default: begin
        br_valid = 1'b0;
        br_taken = 1'b0;
      end
    endcase
  end

  // register file and ALU steering
  always_comb begin
    rd_addr1 = ir_ra;
    rd_addr2 = ir_rb;
    wr_en    = 1'b0;
    wr_addr  = ir_ra;
    wr_data  = alu_result;
    alu_func = `ALU_ADD;
    alu_in1  = rd_data1;
    alu_in2  = rd_data2;
    case (state)
      EVAL1: begin
        if (ir_mode == `MODE_INH) begin
          case (ir_op[7:4])
            `OP_CMP: alu_func = `ALU_SUB;
            `OP_INC: begin
              alu_in2 = 32'd1;
              wr_en   = 1'b1;
            end
            `OP_DEC: begin
              alu_func = `ALU_SUB;
              alu_in2  = 32'd1;
              wr_en    = 1'b1;
            end
            `OP_MOV: begin
              wr_data = rd_data2;
              wr_en   = 1'b1;
            end
            default: wr_en = 1'b0;
          endcase
        end
      end
      EVAL2: begin
        if (ir_mode == `MODE_REG && alu_op_ok) begin
          rd_addr1 = ir_rb;
          rd_addr2 = ir_rc;
          alu_func = ir_op[3:0];
          wr_en    = 1'b1;
        end
      end
      EVAL3: begin
        if (is_ldi) begin
          wr_data = mdr;
          wr_en   = 1'b1;
        end
      end
      LOAD_WB: begin
        wr_data = mdr;
        wr_en   = 1'b1;
      end
      default: wr_en = 1'b0;
    endcase
  end

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      state       <= FETCH;
      pc          <= `BOOT_ADDR;
      ir          <= '0;
      mar         <= '0;
      mdr         <= '0;
      ccr         <= '0;
      word_idx    <= 2'd0;
      mem.req     <= 1'b0;
      mem.is_long <= 1'b0;
      mem.write   <= 1'b0;
      mem.addr    <= '0;
      mem.wdata   <= '0;
    end else begin
      mem.req <= 1'b0;
      case (state)
        FETCH: begin
          mem.req     <= 1'b1;
          mem.is_long <= 1'b0;
          mem.write   <= 1'b0;
          mem.addr    <= pc;
          state       <= FETCH_WAIT;
        end
        FETCH_WAIT: begin
          if (mem.done) begin
            pc <= pc + 32'd2;
            case (word_idx)
              2'd0: begin
                ir    <= {mem.rdata[15:0], 16'h0000};
                state <= EVAL1;
              end
              2'd1: begin
                case (ir_mode)
                  `MODE_IMM2:  mar <= {{16{mem.rdata[15]}}, mem.rdata[15:0]};
                  `MODE_DIR:   mar <= {16'h0000, mem.rdata[15:0]};
                  `MODE_IMM3A: mdr <= {16'h0000, mem.rdata[15:0]};
                  default:     ir[15:0] <= mem.rdata[15:0];
                endcase
                state <= EVAL2;
              end
              default: begin
                if (ir_mode == `MODE_DIR) begin
                  mar <= {mar[15:0], mem.rdata[15:0]};
                end else begin
                  mdr <= {mdr[15:0], mem.rdata[15:0]};
                end
                state <= EVAL3;
              end
            endcase
          end
        end
        EVAL1: begin
          word_idx <= 2'd0;
          state    <= FETCH;
          if (ir_mode == `MODE_INH) begin
            case (ir_op[7:4])
              `OP_CMP: ccr <= alu_flags;
              `OP_NOP, `OP_INC, `OP_DEC, `OP_MOV: state <= FETCH;
              default: state <= FAULT;
            endcase
          end else if (ir_mode == `MODE_REG || ir_mode == `MODE_IMM2 ||
                       ir_mode == `MODE_DIR || ir_mode == `MODE_IMM3A) begin
            word_idx <= 2'd1;
          end else begin
            state <= FAULT;
          end
        end
        EVAL2: begin
          word_idx <= 2'd0;
          state    <= FETCH;
          case (ir_mode)
            `MODE_REG: begin
              if (!alu_op_ok) state <= FAULT;
            end
            `MODE_IMM2: begin
              if (!br_valid) begin
                state <= FAULT;
              end else if (br_taken) begin
                pc <= pc + mar; // offset from the word after the branch
              end
            end
            `MODE_DIR, `MODE_IMM3A: word_idx <= 2'd2;
            default: state <= FAULT;
          endcase
        end
        EVAL3: begin
          word_idx <= 2'd0;
          state    <= FETCH;
          if (is_dir_mem) begin
            mem.req     <= 1'b1;
            mem.is_long <= 1'b1;
            mem.write   <= (ir_op == `OP_STDL);
            mem.addr    <= mar;
            mem.wdata   <= rd_data1; // rA
            state       <= MEM_WAIT;
          end else if (!is_ldi) begin
            state <= FAULT;
          end
        end
        MEM_WAIT: begin
          if (mem.done) begin
            if (mem.write) begin
              state <= FETCH;
            end else begin
              mdr   <= mem.rdata;
              state <= LOAD_WB;
            end
          end
        end
        LOAD_WB: state <= FETCH;
        default: state <= FAULT; // halted
      endcase
    end
  end

endmodule

//--- logic/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
  input  logic       csi_clk,
  input  logic       rsi_reset_n,
  input  logic       avm_m0_waitrequest,
  input  half_t      avm_m0_readdata,
  output word_t      avm_m0_address,
  output logic       avm_m0_read,
  output logic       avm_m0_write,
  output half_t      avm_m0_writedata,
  output logic [1:0] avm_m0_byteenable
);

  mem_req_if mem_bus ();

  reg_addr_t rd_addr1;
  reg_addr_t rd_addr2;
  word_t     rd_data1;
  word_t     rd_data2;
  logic      wr_en;
  reg_addr_t wr_addr;
  word_t     wr_data;
  alu_func_t alu_func;
  word_t     alu_in1;
  word_t     alu_in2;
  word_t     alu_result;
  flags_t    alu_flags;

  cpu_control u_control (
    .csi_clk     (csi_clk),
    .rsi_reset_n (rsi_reset_n),
    .mem         (mem_bus.ctrl),
    .rd_addr1    (rd_addr1),
    .rd_addr2    (rd_addr2),
    .rd_data1    (rd_data1),
    .rd_data2    (rd_data2),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .alu_func    (alu_func),
    .alu_in1     (alu_in1),
    .alu_in2     (alu_in2),
    .alu_result  (alu_result),
    .alu_flags   (alu_flags)
  );

  bus_unit u_bus (
    .csi_clk            (csi_clk),
    .rsi_reset_n        (rsi_reset_n),
    .req                (mem_bus.bus),
    .avm_m0_waitrequest (avm_m0_waitrequest),
    .avm_m0_readdata    (avm_m0_readdata),
    .avm_m0_address     (avm_m0_address),
    .avm_m0_read        (avm_m0_read),
    .avm_m0_write       (avm_m0_write),
    .avm_m0_writedata   (avm_m0_writedata),
    .avm_m0_byteenable  (avm_m0_byteenable)
  );

  register_file u_regs (
    .csi_clk     (csi_clk),
    .rsi_reset_n (rsi_reset_n),
    .rd_addr1    (rd_addr1),
    .rd_addr2    (rd_addr2),
    .rd_data1    (rd_data1),
    .rd_data2    (rd_data2),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data)
  );

  alu u_alu (
    .func   (alu_func),
    .in1    (alu_in1),
    .in2    (alu_in2),
    .result (alu_result),
    .flags  (alu_flags)
  );

endmodule

//--- testbench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam word_t VAL_A = 32'h1234_5678;
localparam word_t VAL_B = 32'h9abc_def0;
localparam word_t VAL_D = 32'h0001_0000; // dec borrows across the halves

// fallthrough stores r2 at fall_addr, taken path stores r1 at taken_addr
task automatic two_way(input logic [4:0] cond, input word_t taken_addr, input word_t fall_addr);
  branch(cond, 16'd10);      // skip store and bra
  std_l(5'd2, fall_addr);
  branch(`BR_BRA, 16'd6);    // skip taken store
  std_l(5'd1, taken_addr);
endtask

task automatic load_program();
  asm_pc = `BOOT_ADDR;
  ldi(5'd1, VAL_A);
  std_l(5'd1, 32'h0000_1000);
  ldi(5'd2, VAL_B);
  alu_rr(`ALU_AND, 5'd3, 5'd1, 5'd2);
  std_l(5'd3, 32'h0000_1004);
  alu_rr(`ALU_OR, 5'd3, 5'd1, 5'd2);
  std_l(5'd3, 32'h0000_1008);
  alu_rr(`ALU_ADD, 5'd3, 5'd1, 5'd2);
  std_l(5'd3, 32'h0000_100c);
  alu_rr(`ALU_SUB, 5'd3, 5'd1, 5'd2);
  std_l(5'd3, 32'h0000_1010);
  alu_rr(`ALU_XOR, 5'd3, 5'd1, 5'd2);
  std_l(5'd3, 32'h0000_1014);
  inherent(`OP_MOV, 5'd4, 5'd2);
  std_l(5'd4, 32'h0000_1018);
  inherent(`OP_INC, 5'd4, 5'd0);
  std_l(5'd4, 32'h0000_101c);
  ldi(5'd5, VAL_D);
  inherent(`OP_DEC, 5'd5, 5'd0);
  std_l(5'd5, 32'h0000_1020);
  inherent(`OP_CMP, 5'd1, 5'd1);  // equal, Z set
  two_way(`BR_BEQ, 32'h0000_1030, 32'h0000_1f30);
  two_way(`BR_BNE, 32'h0000_1f34, 32'h0000_1034);
  inherent(`OP_CMP, 5'd1, 5'd2);  // A below B, borrow
  two_way(`BR_BNE, 32'h0000_1038, 32'h0000_1f38);
  two_way(`BR_BLTU, 32'h0000_103c, 32'h0000_1f3c);
  two_way(`BR_BGEU, 32'h0000_1f40, 32'h0000_1040);
  inherent(`OP_CMP, 5'd2, 5'd1);  // no borrow
  two_way(`BR_BLTU, 32'h0000_1f44, 32'h0000_1044);
  two_way(`BR_BGEU, 32'h0000_1048, 32'h0000_1f48);
  ldd_l(5'd7, 32'h0000_2000);
  std_l(5'd7, 32'h0000_1050);
  branch(`BR_BRA, 16'hfffc);      // park on itself
  mem[32'h0000_2000] = 16'hcafe;
  mem[32'h0000_2002] = 16'hf00d;
endtask

task automatic load_table();
  add_row("ldi_store", 32'h0000_1000, VAL_A);
  add_row("and", 32'h0000_1004, VAL_A & VAL_B);
  add_row("or", 32'h0000_1008, VAL_A | VAL_B);
  add_row("add", 32'h0000_100c, VAL_A + VAL_B);
  add_row("sub", 32'h0000_1010, VAL_A - VAL_B);
  add_row("xor", 32'h0000_1014, VAL_A ^ VAL_B);
  add_row("mov", 32'h0000_1018, VAL_B);
  add_row("inc", 32'h0000_101c, VAL_B + 32'd1);
  add_row("dec", 32'h0000_1020, VAL_D - 32'd1);
  add_row("beq_taken", 32'h0000_1030, VAL_A);
  add_row("bne_not_taken", 32'h0000_1034, VAL_B);
  add_row("bne_taken", 32'h0000_1038, VAL_A);
  add_row("bltu_taken", 32'h0000_103c, VAL_A);
  add_row("bgeu_not_taken", 32'h0000_1040, VAL_B);
  add_row("bltu_not_taken", 32'h0000_1044, VAL_B);
  add_row("bgeu_taken", 32'h0000_1048, VAL_A);
  add_row("ldd_big_endian", 32'h0000_1050, 32'hcafe_f00d);
endtask

`endif

//--- testbench/tb_cpu_core.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_cpu_core import cpu_pkg::*; ();

  localparam int CYCLES_PER_ROW = 400;

  logic        csi_clk            = 1'b0;
  logic        rsi_reset_n        = 1'b0;
  logic        avm_m0_waitrequest = 1'b0;
  half_t       avm_m0_readdata    = '0;
  word_t       avm_m0_address;
  logic        avm_m0_read;
  logic        avm_m0_write;
  half_t       avm_m0_writedata;
  logic [1:0]  avm_m0_byteenable;

  half_t       mem [word_t]; // sparse program and data memory
  word_t       asm_pc;
  string       row_name [$];
  word_t       row_addr [$];
  word_t       row_value [$];
  word_t       wr_addr_q [$];  // accepted write halves, in bus order
  half_t       wr_data_q [$];
  logic [31:0] lfsr          = 32'he1d9_1f29;
  logic        stall_pending = 1'b0;
  logic        accepted_prev = 1'b0;
  logic [1:0]  held_ctl      = 2'b00;
  word_t       held_addr     = '0;
  half_t       held_wdata    = '0;

  cpu_core DUT (
    .csi_clk            (csi_clk),
    .rsi_reset_n        (rsi_reset_n),
    .avm_m0_waitrequest (avm_m0_waitrequest),
    .avm_m0_readdata    (avm_m0_readdata),
    .avm_m0_address     (avm_m0_address),
    .avm_m0_read        (avm_m0_read),
    .avm_m0_write       (avm_m0_write),
    .avm_m0_writedata   (avm_m0_writedata),
    .avm_m0_byteenable  (avm_m0_byteenable)
  );

  always #10 csi_clk = ~csi_clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32,22,2,1
  endfunction

  function automatic half_t read_half(input word_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return a[31:16] ^ a[15:0]; // fill for unloaded addresses
  endfunction

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic put_half(input half_t w);
    mem[asm_pc] = w;
    asm_pc      = asm_pc + 32'd2;
  endtask

  task automatic ldi(input reg_addr_t ra, input word_t value);
    put_half({`MODE_IMM3A, 8'h00, ra});
    put_half(value[31:16]);
    put_half(value[15:0]);
  endtask

  task automatic std_l(input reg_addr_t ra, input word_t addr);
    put_half({`MODE_DIR, `OP_STDL, ra});
    put_half(addr[31:16]);
    put_half(addr[15:0]);
  endtask

  task automatic ldd_l(input reg_addr_t ra, input word_t addr);
    put_half({`MODE_DIR, `OP_LDDL, ra});
    put_half(addr[31:16]);
    put_half(addr[15:0]);
  endtask

  // rA = rB func rC
  task automatic alu_rr(input alu_func_t func, input reg_addr_t ra, input reg_addr_t rb,
                        input reg_addr_t rc);
    put_half({`MODE_REG, 3'b000, rb, ra});
    put_half({1'b0, func, 6'd0, rc});
  endtask

  task automatic inherent(input logic [3:0] op_hi, input reg_addr_t ra, input reg_addr_t rb);
    put_half({`MODE_INH, op_hi[3:1], rb, ra});
  endtask

  task automatic branch(input logic [4:0] cond, input half_t offset);
    put_half({`MODE_IMM2, 3'b000, cond, 5'd0});
    put_half(offset); // byte offset from the word after the branch
  endtask

  task automatic add_row(input string name, input word_t addr, input word_t value);
    row_name.push_back(name);
    row_addr.push_back(addr);
    row_value.push_back(value);
  endtask

  `include "tb_program.svh"

  // memory model, stalls and bus rule checks
  always @(negedge csi_clk) begin
    check_value("byteenable", 32'h3, {30'd0, avm_m0_byteenable});
    if (stall_pending) begin
      check_value("hold_strobes", {30'd0, held_ctl}, {30'd0, avm_m0_read, avm_m0_write});
      check_value("hold_address", held_addr, avm_m0_address);
      check_value("hold_writedata", {16'd0, held_wdata}, {16'd0, avm_m0_writedata});
    end
    if (accepted_prev) begin
      check_value("strobe_gap", 32'd0, {30'd0, avm_m0_read, avm_m0_write});
    end
    lfsr               = lfsr_next(lfsr);
    avm_m0_waitrequest = lfsr[0];
    avm_m0_readdata    = read_half(avm_m0_address);
    stall_pending      = (avm_m0_read | avm_m0_write) & avm_m0_waitrequest;
    accepted_prev      = (avm_m0_read | avm_m0_write) & ~avm_m0_waitrequest;
    held_ctl           = {avm_m0_read, avm_m0_write};
    held_addr          = avm_m0_address;
    held_wdata         = avm_m0_writedata;
    if (avm_m0_write && !avm_m0_waitrequest) begin // accepted at the next rising edge
      mem[avm_m0_address] = avm_m0_writedata;
      wr_addr_q.push_back(avm_m0_address);
      wr_data_q.push_back(avm_m0_writedata);
    end
  end

  initial begin
    @(posedge rsi_reset_n);
    repeat (CYCLES_PER_ROW * row_name.size()) @(posedge csi_clk);
    $display("watchdog expired: the core hung before all expected stores were seen");
    $display("** FAIL **");
    $fatal(1, "run hung");
  end

  initial begin
    word_t hi_addr;
    word_t lo_addr;
    half_t hi_data;
    half_t lo_data;
    load_program();
    load_table();
    rsi_reset_n = 1'b0;
    repeat (4) @(posedge csi_clk);
    @(negedge csi_clk);
    rsi_reset_n = 1'b1;
    for (int i = 0; i < row_name.size(); i++) begin
      while (wr_addr_q.size() < 2) begin
        @(posedge csi_clk);
      end
      hi_addr = wr_addr_q.pop_front();
      hi_data = wr_data_q.pop_front();
      lo_addr = wr_addr_q.pop_front();
      lo_data = wr_data_q.pop_front();
      check_value({row_name[i], "_addr_hi"}, row_addr[i], hi_addr);
      check_value({row_name[i], "_addr_lo"}, row_addr[i] + 32'd2, lo_addr);
      check_value(row_name[i], row_value[i], {hi_data, lo_data});
    end
    repeat (50) @(posedge csi_clk);
    check_value("extra_store", 32'd0, 32'(wr_addr_q.size())); // core parks on its last branch
    $display("** PASS **");
    $finish;
  end

endmodule

//--- flist.f
+incdir+logic
+incdir+testbench
logic/cpu_pkg.sv
logic/mem_req_if.sv
logic/bus_unit.sv
logic/alu.sv
logic/register_file.sv
logic/cpu_control.sv
logic/cpu_core.sv
testbench/tb_cpu_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       ?= tb_cpu_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	  echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
